/* hw/ex_cfg.svh */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Data and address width
`define EX_XLEN 32

// Scoreboard tag width
`define EX_TRANS_ID_BITS 3

// CSR address and SFENCE.VMA ASID widths
`define EX_CSR_ADDR_BITS 12
`define EX_ASID_BITS 9

`endif

/* hw/ex_pkg.sv */
`include "ex_cfg.svh"

package ex_pkg;

    // --------------------------------------------------
    // Functional unit operations
    // --------------------------------------------------
    typedef enum logic [4:0] {
        // ALU
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA,
        SLTS, SLTU,
        // Branch unit
        EQ, NE, LTS, GES, LTU, GEU,
        JAL, JALR,
        // Multiplier
        MUL, MULH, MULHU,
        // CSR path
        CSR_RW, SFENCE_VMA
    } fu_op_e;

    // --------------------------------------------------
    // Data and tag types
    // --------------------------------------------------
    // Operands, results and addresses
    typedef logic [`EX_XLEN-1:0] xlen_t;

    // Scoreboard entry for write-back
    typedef logic [`EX_TRANS_ID_BITS-1:0] trans_id_t;

    typedef logic [`EX_CSR_ADDR_BITS-1:0] csr_addr_t;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps

module alu import ex_pkg::*; (
    input  fu_op_e operation_i,
    input  xlen_t  operand_a_i,
    input  xlen_t  operand_b_i,
    output xlen_t  result_o,
    output logic   branch_cmp_o
);

    logic                             negate_b;
    logic                             signed_cmp;
    logic [$bits(xlen_t):0]           adder_a;
    logic [$bits(xlen_t):0]           adder_b;
    logic [$bits(xlen_t):0]           adder_sum;
    logic                             is_equal;
    logic                             is_less;
    logic [$clog2($bits(xlen_t))-1:0] shamt;

    // --------------------------------------------------
    // Shared adder
    // --------------------------------------------------
    // Subtract for SUB and every compare
    assign negate_b = operation_i inside {SUB, SLTS, SLTU, EQ, NE, LTS, GES, LTU, GEU};
    assign signed_cmp = operation_i inside {SLTS, LTS, GES};

    // One extra bit so signed and unsigned compares both read the top bit
    assign adder_a = {signed_cmp & operand_a_i[$bits(xlen_t)-1], operand_a_i};
    assign adder_b = {signed_cmp & operand_b_i[$bits(xlen_t)-1], operand_b_i}
                     ^ {($bits(xlen_t) + 1){negate_b}};

    assign adder_sum = adder_a + adder_b + {{$bits(xlen_t){1'b0}}, negate_b};

    assign is_equal = ~|adder_sum[$bits(xlen_t)-1:0];
    assign is_less  = adder_sum[$bits(xlen_t)];

    assign shamt = operand_b_i[$clog2($bits(xlen_t))-1:0];

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        result_o = '0;
        case (operation_i)
            ADD, SUB: result_o = adder_sum[$bits(xlen_t)-1:0];
            AND:      result_o = operand_a_i & operand_b_i;
            OR:       result_o = operand_a_i | operand_b_i;
            XOR:      result_o = operand_a_i ^ operand_b_i;
            SLL:      result_o = operand_a_i << shamt;
            SRL:      result_o = operand_a_i >> shamt;
            SRA:      result_o = xlen_t'($signed(operand_a_i) >>> shamt);
            SLTS, SLTU: begin
                result_o = {{($bits(xlen_t) - 1){1'b0}}, is_less};
            end
            default:  result_o = '0;
        endcase
    end

    // Branch condition
    always_comb begin
        case (operation_i)
            EQ:       branch_cmp_o = is_equal;
            NE:       branch_cmp_o = ~is_equal;
            LTS, LTU: branch_cmp_o = is_less;
            GES, GEU: branch_cmp_o = ~is_less;
            default:  branch_cmp_o = 1'b1;
        endcase
    end

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import ex_pkg::*; (
    input  fu_op_e operation_i,
    input  xlen_t  operand_a_i,
    input  xlen_t  imm_i,
    input  xlen_t  pc_i,
    input  logic   is_compressed_i,
    input  logic   branch_valid_i,
    input  logic   branch_cmp_i,
    input  logic   predict_taken_i,
    input  xlen_t  predict_target_i,
    output xlen_t  link_addr_o,
    output logic   resolve_branch_o,
    output logic   mispredict_o,
    output xlen_t  resolved_target_o,
    output logic   branch_exception_o
);

    logic  is_jalr;
    logic  is_jump;
    logic  taken;
    xlen_t target_base;
    xlen_t target_sum;
    xlen_t target;

    assign is_jalr = (operation_i == JALR);
    assign is_jump = (operation_i == JAL) || is_jalr;

    // --------------------------------------------------
    // Target and link address
    // --------------------------------------------------
    // JALR is register relative, the rest pc relative
    assign target_base = is_jalr ? operand_a_i : pc_i;
    assign target_sum  = target_base + imm_i;

    always_comb begin
        target = target_sum;
        if (is_jalr) begin
            target[0] = 1'b0;
        end
    end

    // Return address skips the instruction itself
    assign link_addr_o = pc_i + (is_compressed_i ? xlen_t'(2) : xlen_t'(4));

    // --------------------------------------------------
    // Resolution
    // --------------------------------------------------
    assign taken = is_jump | branch_cmp_i;

    assign resolve_branch_o  = branch_valid_i;
    assign resolved_target_o = taken ? target : link_addr_o;

    // Wrong direction, or right direction with a wrong target
    assign mispredict_o = branch_valid_i &
                          ((taken != predict_taken_i) ||
                           (taken && (target != predict_target_i)));

    // C extension present so only bit 0 can misalign
    assign branch_exception_o = branch_valid_i & taken & target[0];

endmodule

/* hw/csr_buffer.sv */
`timescale 1ns/1ps

module csr_buffer import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      csr_valid_i,
    input  xlen_t     imm_i,
    input  logic      csr_commit_i,
    output logic      csr_ready_o,
    output csr_addr_t csr_addr_o
);

    logic      valid_q;
    csr_addr_t addr_q;

    // --------------------------------------------------
    // Occupancy
    // --------------------------------------------------
    // Single entry, so any CSR blocks further CSR issue until commit
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (csr_valid_i) begin
            valid_q <= 1'b1;
        end else if (csr_commit_i) begin
            valid_q <= 1'b0;
        end
    end

    // CSR address sits in the low immediate bits
    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= imm_i[$bits(csr_addr_t)-1:0];
        end
    end

    assign csr_ready_o = ~valid_q;
    assign csr_addr_o  = addr_q;

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // Issue logic must hold CSRs back until the entry retires
    csr_issue_when_full_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        valid_q |-> !csr_valid_i
    ) else $error("csr_buffer: CSR issued while buffer full");

endmodule

/* hw/mult.sv */
`timescale 1ns/1ps

module mult import ex_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      mult_valid_i,
    input  fu_op_e    operation_i,
    input  xlen_t     operand_a_i,
    input  xlen_t     operand_b_i,
    input  trans_id_t trans_id_i,
    output logic      mult_valid_o,
    output xlen_t     result_o,
    output trans_id_t trans_id_o
);

    logic                                signed_ops;
    logic signed [$bits(xlen_t):0]       mult_a;
    logic signed [$bits(xlen_t):0]       mult_b;
    logic signed [2*$bits(xlen_t)+1:0]   product;
    xlen_t                               result_d;
    logic                                valid_q;
    xlen_t                               result_q;
    trans_id_t                           trans_id_q;

    // --------------------------------------------------
    // Product
    // --------------------------------------------------
    // MULHU zero extends, MUL and MULH sign extend
    assign signed_ops = (operation_i != MULHU);
    assign mult_a = {signed_ops & operand_a_i[$bits(xlen_t)-1], operand_a_i};
    assign mult_b = {signed_ops & operand_b_i[$bits(xlen_t)-1], operand_b_i};
    assign product = mult_a * mult_b;

    assign result_d = (operation_i == MUL) ? product[$bits(xlen_t)-1:0]
                                           : product[2*$bits(xlen_t)-1:$bits(xlen_t)];

    // Output stage, one cycle latency
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= result_d;
            trans_id_q <= trans_id_i;
        end
    end

    assign mult_valid_o = valid_q;
    assign result_o     = result_q;
    assign trans_id_o   = trans_id_q;

    // Any other opcode would silently return a high product
    issue_op_is_mult_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i |-> (operation_i inside {MUL, MULH, MULHU})
    ) else $error("mult: non-multiply operation on the multiply strobe");

endmodule

/* hw/tlb_flush_capture.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tlb_flush_capture import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     csr_valid_i,
    input  fu_op_e                   operation_i,
    input  xlen_t                    operand_a_i,
    input  xlen_t                    operand_b_i,
    output logic                     sfence_pending_o,
    output xlen_t                    flush_vaddr_o,
    output logic [`EX_ASID_BITS-1:0] flush_asid_o
);

    logic                     is_sfence;
    logic                     pending_q;
    xlen_t                    vaddr_q;
    logic [`EX_ASID_BITS-1:0] asid_q;

    // SFENCE.VMA travels on the CSR strobe
    assign is_sfence = csr_valid_i && (operation_i == SFENCE_VMA);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
        end else if (flush_i) begin
            pending_q <= 1'b0;
        end else if (is_sfence) begin
            pending_q <= 1'b1;
        end
    end

    // First fence wins until the pipeline flush
    always_ff @(posedge clk_i) begin
        if (is_sfence && !pending_q) begin
            vaddr_q <= operand_a_i;
            asid_q  <= operand_b_i[`EX_ASID_BITS-1:0];
        end
    end

    assign sfence_pending_o = pending_q;
    assign flush_vaddr_o    = vaddr_q;
    assign flush_asid_o     = asid_q;

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // Issue bus
    input  fu_op_e                   operation_i,
    input  xlen_t                    operand_a_i,
    input  xlen_t                    operand_b_i,
    input  xlen_t                    imm_i,
    input  trans_id_t                trans_id_i,
    input  xlen_t                    pc_i,
    input  logic                     is_compressed_i,
    input  logic                     alu_valid_i,
    input  logic                     branch_valid_i,
    input  logic                     csr_valid_i,
    input  logic                     mult_valid_i,
    input  logic                     predict_taken_i,
    input  xlen_t                    predict_target_i,
    input  logic                     csr_commit_i,
    // Write-back
    output xlen_t                    flu_result_o,
    output trans_id_t                flu_trans_id_o,
    output logic                     flu_valid_o,
    output logic                     flu_ready_o,
    // Branch resolution
    output logic                     resolve_branch_o,
    output logic                     mispredict_o,
    output xlen_t                    resolved_target_o,
    output logic                     branch_exception_o,
    output csr_addr_t                csr_addr_o,
    // TLB flush request
    output logic                     sfence_pending_o,
    output xlen_t                    flush_vaddr_o,
    output logic [`EX_ASID_BITS-1:0] flush_asid_o
);

    xlen_t     alu_result;
    logic      alu_branch_cmp;
    xlen_t     link_addr;
    logic      csr_ready;
    logic      mult_valid;
    xlen_t     mult_result;
    trans_id_t mult_trans_id;

    // --------------------------------------------------
    // Fixed latency units
    // --------------------------------------------------
    alu u_alu (
        .operation_i  (operation_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .result_o     (alu_result),
        .branch_cmp_o (alu_branch_cmp)
    );

    branch_unit u_branch_unit (
        .operation_i        (operation_i),
        .operand_a_i        (operand_a_i),
        .imm_i              (imm_i),
        .pc_i               (pc_i),
        .is_compressed_i    (is_compressed_i),
        .branch_valid_i     (branch_valid_i),
        .branch_cmp_i       (alu_branch_cmp),
        .predict_taken_i    (predict_taken_i),
        .predict_target_i   (predict_target_i),
        .link_addr_o        (link_addr),
        .resolve_branch_o   (resolve_branch_o),
        .mispredict_o       (mispredict_o),
        .resolved_target_o  (resolved_target_o),
        .branch_exception_o (branch_exception_o)
    );

    csr_buffer u_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .imm_i        (imm_i),
        .csr_commit_i (csr_commit_i),
        .csr_ready_o  (csr_ready),
        .csr_addr_o   (csr_addr_o)
    );

    mult u_mult (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .mult_valid_i (mult_valid_i),
        .operation_i  (operation_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .trans_id_i   (trans_id_i),
        .mult_valid_o (mult_valid),
        .result_o     (mult_result),
        .trans_id_o   (mult_trans_id)
    );

    tlb_flush_capture u_tlb_flush_capture (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .csr_valid_i      (csr_valid_i),
        .operation_i      (operation_i),
        .operand_a_i      (operand_a_i),
        .operand_b_i      (operand_b_i),
        .sfence_pending_o (sfence_pending_o),
        .flush_vaddr_o    (flush_vaddr_o),
        .flush_asid_o     (flush_asid_o)
    );

    // --------------------------------------------------
    // Write-back mux
    // --------------------------------------------------
    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_valid;
    assign flu_ready_o = csr_ready;

    always_comb begin
        // Branch link address by default
        flu_result_o   = link_addr;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result;
        end else if (csr_valid_i) begin
            // CSR writes back rs1, the CSR itself is read at commit
            flu_result_o = operand_a_i;
        end else if (mult_valid) begin
            flu_result_o   = mult_result;
            flu_trans_id_o = mult_trans_id;
        end
    end

    // --------------------------------------------------
    // Issue rule checks
    // --------------------------------------------------
    strobe_onehot_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i})
    ) else $error("ex_stage: more than one unit strobe high");

    // Multiplier owns the write-back port one cycle after its issue
    mult_port_clash_a: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mult_valid |-> !(alu_valid_i | branch_valid_i | csr_valid_i | mult_valid_i)
    ) else $error("ex_stage: issue collides with multiplier write-back");

endmodule

/* verification/ex_model.svh */
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// --------------------------------------------------
// ALU reference
// --------------------------------------------------
function automatic xlen_t model_alu(input fu_op_e op, input xlen_t a, input xlen_t b);
    xlen_t r;
    r = '0;
    case (op)
        ADD:     r = a + b;
        SUB:     r = a - b;
        AND:     r = a & b;
        OR:      r = a | b;
        XOR:     r = a ^ b;
        SLL:     r = a << b[4:0];
        SRL:     r = a >> b[4:0];
        SRA:     r = xlen_t'($signed(a) >>> b[4:0]);
        SLTS:    r = xlen_t'($signed(a) < $signed(b));
        SLTU:    r = xlen_t'(a < b);
        default: r = '0;
    endcase
    return r;
endfunction

// Conditional branch outcome, jumps always taken
function automatic logic model_cond(input fu_op_e op, input xlen_t a, input xlen_t b);
    case (op)
        EQ:      return a == b;
        NE:      return a != b;
        LTS:     return $signed(a) < $signed(b);
        GES:     return $signed(a) >= $signed(b);
        LTU:     return a < b;
        GEU:     return a >= b;
        default: return 1'b1;
    endcase
endfunction

// --------------------------------------------------
// Multiplier reference
// --------------------------------------------------
function automatic xlen_t model_mult(input fu_op_e op, input xlen_t a, input xlen_t b);
    logic [2*`EX_XLEN-1:0] wide_a;
    logic [2*`EX_XLEN-1:0] wide_b;
    logic [2*`EX_XLEN-1:0] p;
    // Only MULHU treats both operands as unsigned
    if (op == MULHU) begin
        wide_a = {{`EX_XLEN{1'b0}}, a};
        wide_b = {{`EX_XLEN{1'b0}}, b};
    end else begin
        wide_a = {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
        wide_b = {{`EX_XLEN{b[`EX_XLEN-1]}}, b};
    end
    p = wide_a * wide_b;
    return (op == MUL) ? p[`EX_XLEN-1:0] : p[2*`EX_XLEN-1:`EX_XLEN];
endfunction

// --------------------------------------------------
// Branch resolution reference
// --------------------------------------------------
function automatic void model_branch(
    input  fu_op_e op,
    input  xlen_t  a,
    input  xlen_t  b,
    input  xlen_t  imm,
    input  xlen_t  pc,
    input  logic   compressed,
    input  logic   pred_taken,
    input  xlen_t  pred_target,
    output logic   mispredict,
    output xlen_t  target,
    output logic   exception,
    output xlen_t  link
);
    logic  taken;
    xlen_t jump_to;
    link  = compressed ? pc + 2 : pc + 4;
    taken = (op == JAL) || (op == JALR) || model_cond(op, a, b);
    jump_to = (op == JALR) ? ((a + imm) & ~xlen_t'(1)) : (pc + imm);
    target     = taken ? jump_to : link;
    mispredict = (taken != pred_taken) || (taken && (jump_to != pred_target));
    // Odd target is the only misalignment with C present
    exception  = taken && jump_to[0];
endfunction

`endif

/* verification/ex_stage_tb.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage_tb import ex_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int SETTLE       = 25;
    localparam int RESET_CYCLES = 8;
    localparam int N_ALU        = 150;
    localparam int N_BRANCH     = 200;
    localparam int N_MULT       = 100;
    localparam int N_CSR        = 30;
    localparam int N_SFENCE     = 8;
    // Multiply takes 2 cycles, CSR 2, fence round 6
    localparam int TEST_CYCLES  =
        N_ALU + N_BRANCH + 2 * N_MULT + 2 * N_CSR + 6 * N_SFENCE + 2;

    logic                     clk_i;
    logic                     rst_ni;
    logic                     flush_i;
    fu_op_e                   operation_i;
    xlen_t                    operand_a_i, operand_b_i, imm_i, pc_i, predict_target_i;
    trans_id_t                trans_id_i;
    logic                     is_compressed_i, predict_taken_i, csr_commit_i;
    logic                     alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i;
    xlen_t                    flu_result_o, resolved_target_o, flush_vaddr_o;
    trans_id_t                flu_trans_id_o;
    logic                     flu_valid_o, flu_ready_o, sfence_pending_o;
    logic                     resolve_branch_o, mispredict_o, branch_exception_o;
    csr_addr_t                csr_addr_o;
    logic [`EX_ASID_BITS-1:0] flush_asid_o;

    int        result_errors;
    int        branch_errors;
    int        flag_errors;
    xlen_t     mult_exp_q[$];
    trans_id_t mult_id_q[$];

    `include "ex_model.svh"

    ex_stage u_dut (.*);

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_result(input xlen_t exp_result, input trans_id_t exp_id);
        if (flu_valid_o !== 1'b1 || flu_result_o !== exp_result || flu_trans_id_o !== exp_id) begin
            result_errors++;
            $display("** Error at %0t: write-back valid %b result %h tag %0d, expected %h tag %0d",
                     $time, flu_valid_o, flu_result_o, flu_trans_id_o, exp_result, exp_id);
        end
    endtask

    task automatic check_branch(input logic exp_mis, input xlen_t exp_target, input logic exp_exc);
        if (resolve_branch_o !== 1'b1 || mispredict_o !== exp_mis ||
            resolved_target_o !== exp_target || branch_exception_o !== exp_exc) begin
            branch_errors++;
            $display("** Error at %0t: branch mis %b target %h exc %b, expected %b %h %b",
                     $time, mispredict_o, resolved_target_o, branch_exception_o,
                     exp_mis, exp_target, exp_exc);
        end
    endtask

    task automatic check_flag(input string what, input logic act_flag, input logic exp_flag,
                              input xlen_t act_word, input xlen_t exp_word);
        if (act_flag !== exp_flag || act_word !== exp_word) begin
            flag_errors++;
            $display("** Error at %0t: %s flag %b word %h, expected flag %b word %h",
                     $time, what, act_flag, act_word, exp_flag, exp_word);
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic randomize_bus();
        operand_a_i      = xlen_t'($urandom());
        operand_b_i      = xlen_t'($urandom());
        imm_i            = xlen_t'($urandom());
        pc_i             = xlen_t'($urandom());
        trans_id_i       = trans_id_t'($urandom());
        is_compressed_i  = 1'($urandom_range(0, 1));
        predict_taken_i  = 1'($urandom_range(0, 1));
        predict_target_i = xlen_t'($urandom());
    endtask

    // Falling edge, then all strobes back to idle
    task automatic next_cycle();
        @(negedge clk_i);
        alu_valid_i    = 1'b0;
        branch_valid_i = 1'b0;
        csr_valid_i    = 1'b0;
        mult_valid_i   = 1'b0;
        flush_i        = 1'b0;
        csr_commit_i   = 1'b0;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic run_alu();
        for (int i = 0; i < N_ALU; i++) begin
            next_cycle();
            randomize_bus();
            operation_i = fu_op_e'(int'(ADD) + $urandom_range(0, 9));
            alu_valid_i = 1'b1;
            #(SETTLE);
            check_result(model_alu(operation_i, operand_a_i, operand_b_i), trans_id_i);
        end
    endtask

    task automatic run_branch();
        logic  exp_mis;
        logic  exp_exc;
        xlen_t exp_target;
        xlen_t exp_link;
        for (int i = 0; i < N_BRANCH; i++) begin
            next_cycle();
            randomize_bus();
            operation_i = fu_op_e'(int'(EQ) + $urandom_range(0, 7));
            if ($urandom_range(0, 3) == 0) begin
                operand_b_i = operand_a_i;
            end
            pc_i[0] = 1'b0;
            // JAL keeps odd immediates to reach the misaligned target
            if (operation_i != JAL && operation_i != JALR) begin
                imm_i[0] = 1'b0;
            end
            case ($urandom_range(0, 2))
                0:       predict_target_i = pc_i + imm_i;
                1:       predict_target_i = (operand_a_i + imm_i) & ~xlen_t'(1);
                default: ;
            endcase
            branch_valid_i = 1'b1;
            model_branch(operation_i, operand_a_i, operand_b_i, imm_i, pc_i, is_compressed_i,
                         predict_taken_i, predict_target_i, exp_mis, exp_target, exp_exc,
                         exp_link);
            #(SETTLE);
            check_branch(exp_mis, exp_target, exp_exc);
            check_result(exp_link, trans_id_i);
        end
    endtask

    task automatic run_mult();
        logic kill;
        for (int i = 0; i < N_MULT; i++) begin
            next_cycle();
            randomize_bus();
            operation_i  = fu_op_e'(int'(MUL) + $urandom_range(0, 2));
            kill         = ($urandom_range(0, 7) == 0);
            mult_valid_i = 1'b1;
            flush_i      = kill;
            if (!kill) begin
                mult_exp_q.push_back(model_mult(operation_i, operand_a_i, operand_b_i));
                mult_id_q.push_back(trans_id_i);
            end
            // Write-back slot belongs to the multiplier, nothing issues
            next_cycle();
            #(SETTLE);
            if (kill) begin
                check_flag("valid after flushed multiply", flu_valid_o, 1'b0, '0, '0);
            end else begin
                check_result(mult_exp_q.pop_front(), mult_id_q.pop_front());
            end
        end
    endtask

    task automatic run_csr();
        csr_addr_t exp_addr;
        for (int i = 0; i < N_CSR; i++) begin
            next_cycle();
            if (!flu_ready_o) begin
                flag_errors++;
                $display("CSR buffer still busy when the next CSR was due to issue");
                continue;
            end
            randomize_bus();
            operation_i = CSR_RW;
            csr_valid_i = 1'b1;
            exp_addr    = imm_i[`EX_CSR_ADDR_BITS-1:0];
            #(SETTLE);
            check_result(operand_a_i, trans_id_i);
            next_cycle();
            csr_commit_i = 1'b1;
            #(SETTLE);
            check_flag("CSR buffer full", flu_ready_o, 1'b0,
                       xlen_t'(csr_addr_o), xlen_t'(exp_addr));
        end
    endtask

    task automatic run_sfence();
        xlen_t exp_vaddr;
        xlen_t exp_asid;
        for (int i = 0; i < N_SFENCE; i++) begin
            next_cycle();
            randomize_bus();
            operation_i = SFENCE_VMA;
            csr_valid_i = 1'b1;
            exp_vaddr   = operand_a_i;
            exp_asid    = xlen_t'(operand_b_i[`EX_ASID_BITS-1:0]);
            #(SETTLE);
            check_flag("fence pending early", sfence_pending_o, 1'b0, '0, '0);
            // Commit frees the buffer for a second fence
            for (int j = 0; j < 4; j++) begin
                next_cycle();
                csr_commit_i = (j == 0 || j == 2);
                flush_i      = (j == 3);
                if (j == 1) begin
                    randomize_bus();
                    operation_i = SFENCE_VMA;
                    csr_valid_i = 1'b1;
                end
                #(SETTLE);
                check_flag("fence vaddr", sfence_pending_o, 1'b1, flush_vaddr_o, exp_vaddr);
                check_flag("fence asid", sfence_pending_o, 1'b1, xlen_t'(flush_asid_o), exp_asid);
            end
            next_cycle();
            #(SETTLE);
            check_flag("fence pending after flush", sfence_pending_o, 1'b0, '0, '0);
        end
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h7bbc));
        result_errors = 0;
        branch_errors = 0;
        flag_errors   = 0;
        rst_ni        = 1'b0;
        operation_i   = ADD;
        randomize_bus();
        alu_valid_i    = 1'b0;
        branch_valid_i = 1'b0;
        csr_valid_i    = 1'b0;
        mult_valid_i   = 1'b0;
        flush_i        = 1'b0;
        csr_commit_i   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #(SETTLE);
        check_flag("valid after reset", flu_valid_o, 1'b0, '0, '0);
        check_flag("resolve after reset", resolve_branch_o, 1'b0, '0, '0);
        check_flag("fence pending after reset", sfence_pending_o, 1'b0, '0, '0);
        check_flag("ready after reset", flu_ready_o, 1'b1, '0, '0);

        run_alu();
        run_branch();
        run_mult();
        run_csr();
        run_sfence();
        next_cycle();

        $display("Errors: result %0d, branch %0d, flag %0d",
                 result_errors, branch_errors, flag_errors);
        if (result_errors + branch_errors + flag_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hw
+incdir+verification
hw/ex_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/csr_buffer.sv
hw/mult.sv
hw/tlb_flush_capture.sv
hw/ex_stage.sv
verification/ex_stage_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ex_stage_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh verification/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
